// File: stream_dispatch.f
disp_pkg.sv
fifo_element.sv
stream_disp_fork.sv
stream_disp_format.sv
stream_disp_router.sv
stream_dispatch.sv
tb_stream_dispatch.sv

// File: run_sim.sh
#!/bin/sh
# Build the dispatcher testbench with Verilator, run it and check the log
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert \
  --timescale 1ns/100ps \
  --top-module tb_stream_dispatch \
  -f stream_dispatch.f \
  -o sim_tb

status=0
./obj_dir/sim_tb > sim.log 2>&1 || status=$?
cat sim.log

if [ "$status" -eq 0 ] && grep -qF "*** TEST PASSED ***" sim.log; then
  echo "Simulation passed"
  exit 0
fi
echo "Simulation failed"
exit 1

// File: tb_stream_dispatch.sv
// Directed testbench for the coefficient dispatcher, compiled through the file list by run_sim.sh
module tb_stream_dispatch;

  timeunit 1ns;
  timeprecision 100ps;

  import disp_pkg::*;

  localparam int CLK_PERIOD  = 40;
  localparam int RST_CYCLES  = 8;
  localparam int SEED        = 13;
  // Beats sent by tests 2 to 5
  localparam int TOTAL_BEATS = 25;
  localparam int BEAT_CYCLES = 40;
  localparam int MARGIN_CYC  = 400;
  localparam int WATCHDOG_NS = (TOTAL_BEATS * BEAT_CYCLES + MARGIN_CYC) * CLK_PERIOD;
  localparam int DRAIN_LIMIT = 400;

  logic                   clk;
  logic                   s_rst_n;
  in_beat_t               in_data_i;
  logic                   in_vld_i;
  logic                   in_rdy_o;
  out_beat_t [OUT_NB-1:0] out_data_o;
  logic [OUT_NB-1:0]      out_vld_o;
  logic [OUT_NB-1:0]      out_rdy_i;

  int   seed;
  int   pass_cnt;
  int   fail_cnt;
  int   beat_idx;
  logic rdy_random;

  // Expected beats per output port, in arrival order
  out_beat_t exp_q [OUT_NB][$];

  stream_dispatch i_stream_dispatch (
    .clk        (clk),
    .s_rst_n    (s_rst_n),
    .in_data_i  (in_data_i),
    .in_vld_i   (in_vld_i),
    .in_rdy_o   (in_rdy_o),
    .out_data_o (out_data_o),
    .out_vld_o  (out_vld_o),
    .out_rdy_i  (out_rdy_i)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  initial begin
    #(WATCHDOG_NS);
    $display("Timeout: the tests did not complete within %0d ns", WATCHDOG_NS);
    $display("*** TEST FAILED ***");
    $finish;
  end

  // ----------------------------------------------------------
  // Checking and reference model
  // ----------------------------------------------------------
  task automatic check_value(input string name, input logic [31:0] actual,
                             input logic [31:0] expected);
    if (actual !== expected) begin
      $display("FAILED %s: got 0x%0h, expected 0x%0h", name, actual, expected);
      fail_cnt++;
    end else begin
      pass_cnt++;
    end
  endtask

  // Even beats go to outputs 0 and 1, odd beats to outputs 2 and 3
  task automatic push_expected(input in_beat_t b);
    int base;
    int n;
    base = (beat_idx % 2 == 0) ? 0 : 2;
    for (int g = 0; g < 2; g++) begin
      for (int p = 0; p < 2; p++) begin
        n = 4 * g + 2 * p;
        exp_q[base + g].push_back({b[n + 1], b[n]});
      end
    end
    beat_idx++;
  endtask

  // Sampled at the falling edge, where both sides of every link are stable
  always @(negedge clk) begin : monitor
    out_beat_t exp_beat;
    if (s_rst_n) begin
      for (int o = 0; o < OUT_NB; o++) begin
        if (out_vld_o[o] && out_rdy_i[o]) begin
          if (exp_q[o].size() == 0) begin
            $display("Unexpected beat on output %0d while none was pending", o);
            fail_cnt++;
          end else begin
            exp_beat = exp_q[o].pop_front();
            check_value($sformatf("out_data_o[%0d]", o), out_data_o[o], exp_beat);
          end
        end
      end
    end
  end

  // New ready pattern on every cycle while enabled
  always @(posedge clk) begin
    if (rdy_random) begin
      #5;
      out_rdy_i = 4'($random(seed));
    end
  end

  // ----------------------------------------------------------
  // Stimulus helpers
  // ----------------------------------------------------------
  function automatic in_beat_t make_beat(input int tag);
    in_beat_t b;
    for (int j = 0; j < IN_COEF; j++) begin
      b[j] = coef_t'(tag * 16 + j);
    end
    return b;
  endfunction

  task automatic random_beat(output in_beat_t b);
    for (int j = 0; j < IN_COEF; j++) begin
      b[j] = coef_t'($random(seed));
    end
  endtask

  // Called 5 ns after a rising edge, returns at the same phase
  task automatic send_beat(input in_beat_t b);
    logic accepted;
    push_expected(b);
    in_data_i = b;
    in_vld_i  = 1'b1;
    accepted  = 1'b0;
    while (!accepted) begin
      @(negedge clk);
      accepted = in_rdy_o;
      @(posedge clk);
      #5;
    end
    in_vld_i = 1'b0;
  endtask

  task automatic wait_drain();
    int cycles;
    int pending;
    cycles  = 0;
    pending = 1;
    while (pending != 0 && cycles < DRAIN_LIMIT) begin
      @(negedge clk);
      cycles++;
      pending = 0;
      for (int o = 0; o < OUT_NB; o++) pending += exp_q[o].size();
    end
    for (int o = 0; o < OUT_NB; o++) begin
      if (exp_q[o].size() != 0) begin
        $display("Output %0d never delivered %0d expected beats", o, exp_q[o].size());
        fail_cnt++;
      end
    end
    // A few idle cycles so that extra beats are caught
    repeat (10) @(negedge clk);
    @(posedge clk);
    #5;
  endtask

  task automatic report_test(input string name, input int fails_before);
    $display("%s finished with %0d failed checks", name, fail_cnt - fails_before);
  endtask

  // ----------------------------------------------------------
  // Tests
  // ----------------------------------------------------------
  task automatic test_reset_idle();
    int fails_before;
    fails_before = fail_cnt;
    check_value("in_rdy_o", 32'(in_rdy_o), 32'd1);
    repeat (10) begin
      @(negedge clk);
      check_value("out_vld_o", 32'(out_vld_o), 32'd0);
    end
    @(posedge clk);
    #5;
    report_test("test_reset_idle", fails_before);
  endtask

  task automatic test_single_beat();
    int fails_before;
    fails_before = fail_cnt;
    send_beat(make_beat(1));
    wait_drain();
    report_test("test_single_beat", fails_before);
  endtask

  task automatic test_four_beats();
    int fails_before;
    fails_before = fail_cnt;
    for (int i = 0; i < 4; i++) send_beat(make_beat(16 + i));
    wait_drain();
    report_test("test_four_beats", fails_before);
  endtask

  task automatic test_random_ready();
    int       fails_before;
    in_beat_t b;
    fails_before = fail_cnt;
    rdy_random   = 1'b1;
    for (int i = 0; i < 16; i++) begin
      random_beat(b);
      send_beat(b);
    end
    wait_drain();
    rdy_random = 1'b0;
    @(posedge clk);
    #5;
    out_rdy_i = '1;
    report_test("test_random_ready", fails_before);
  endtask

  task automatic test_stall_out0();
    int        fails_before;
    int        cycles;
    out_beat_t held;
    fails_before = fail_cnt;
    out_rdy_i    = 4'b1110;
    fork
      for (int i = 0; i < 4; i++) send_beat(make_beat(48 + i));
      begin
        cycles = 0;
        @(negedge clk);
        while (!out_vld_o[0] && cycles < DRAIN_LIMIT) begin
          @(negedge clk);
          cycles++;
        end
        if (!out_vld_o[0]) begin
          $display("Output 0 never became valid while it was stalled");
          fail_cnt++;
        end
        held = out_data_o[0];
        repeat (20) begin
          @(negedge clk);
          check_value("out_vld_o[0]", 32'(out_vld_o[0]), 32'd1);
          check_value("out_data_o[0]", out_data_o[0], held);
        end
        @(posedge clk);
        #5;
        out_rdy_i[0] = 1'b1;
      end
    join
    wait_drain();
    report_test("test_stall_out0", fails_before);
  endtask

  initial begin
    seed       = SEED;
    pass_cnt   = 0;
    fail_cnt   = 0;
    beat_idx   = 0;
    rdy_random = 1'b0;
    s_rst_n    = 1'b0;
    in_data_i  = '0;
    in_vld_i   = 1'b0;
    out_rdy_i  = '1;
    repeat (RST_CYCLES) @(posedge clk);
    #5;
    s_rst_n = 1'b1;
    @(posedge clk);
    #5;

    test_reset_idle();
    test_single_beat();
    test_four_beats();
    test_random_ready();
    test_stall_out0();

    $display("Checks passed: %0d, checks failed: %0d", pass_cnt, fail_cnt);
    if (fail_cnt == 0) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  end

endmodule

// File: stream_dispatch.sv
// Top level of the coefficient dispatcher: input buffer, fork, format cores, router, output buffers
module stream_dispatch (
  input  logic                                     clk,
  input  logic                                     s_rst_n,

  input  disp_pkg::in_beat_t                       in_data_i,
  input  logic                                     in_vld_i,
  output logic                                     in_rdy_o,

  output disp_pkg::out_beat_t [disp_pkg::OUT_NB-1:0] out_data_o,
  output logic [disp_pkg::OUT_NB-1:0]               out_vld_o,
  input  logic [disp_pkg::OUT_NB-1:0]               out_rdy_i
);

  import disp_pkg::*;

  in_beat_t                    s0_data;
  logic                        s0_vld;
  logic                        s0_rdy;

  grp_t      [FMT_CORE_NB-1:0] f0_data;
  logic      [FMT_CORE_NB-1:0] f0_vld;
  logic      [FMT_CORE_NB-1:0] f0_rdy;

  out_beat_t [FMT_CORE_NB-1:0] f1_data;
  logic      [FMT_CORE_NB-1:0] f1_vld;
  logic      [FMT_CORE_NB-1:0] f1_rdy;

  out_beat_t [OUT_NB-1:0]      f2_data;
  logic      [OUT_NB-1:0]      f2_vld;
  logic      [OUT_NB-1:0]      f2_rdy;

  // ----------------------------------------------------------
  // Input buffer and fork
  // ----------------------------------------------------------
  fifo_element #(
    .payload_t (in_beat_t)
  ) i_in_fifo (
    .clk        (clk),
    .s_rst_n    (s_rst_n),
    .in_data_i  (in_data_i),
    .in_vld_i   (in_vld_i),
    .in_rdy_o   (in_rdy_o),
    .out_data_o (s0_data),
    .out_vld_o  (s0_vld),
    .out_rdy_i  (s0_rdy)
  );

  stream_disp_fork i_fork (
    .clk       (clk),
    .s_rst_n   (s_rst_n),
    .s0_data_i (s0_data),
    .s0_vld_i  (s0_vld),
    .s0_rdy_o  (s0_rdy),
    .f0_data_o (f0_data),
    .f0_vld_o  (f0_vld),
    .f0_rdy_i  (f0_rdy)
  );

  // ----------------------------------------------------------
  // Format cores
  // ----------------------------------------------------------
  for (genvar gc = 0; gc < FMT_CORE_NB; gc++) begin : gen_format
    stream_disp_format i_format (
      .clk        (clk),
      .s_rst_n    (s_rst_n),
      .in_data_i  (f0_data[gc]),
      .in_vld_i   (f0_vld[gc]),
      .in_rdy_o   (f0_rdy[gc]),
      .out_data_o (f1_data[gc]),
      .out_vld_o  (f1_vld[gc]),
      .out_rdy_i  (f1_rdy[gc])
    );
  end

  // ----------------------------------------------------------
  // Router and output buffers
  // ----------------------------------------------------------
  stream_disp_router i_router (
    .clk       (clk),
    .s_rst_n   (s_rst_n),
    .f1_data_i (f1_data),
    .f1_vld_i  (f1_vld),
    .f1_rdy_o  (f1_rdy),
    .f2_data_o (f2_data),
    .f2_vld_o  (f2_vld),
    .f2_rdy_i  (f2_rdy)
  );

  for (genvar go = 0; go < OUT_NB; go++) begin : gen_out_fifo
    fifo_element #(
      .payload_t (out_beat_t)
    ) i_out_fifo (
      .clk        (clk),
      .s_rst_n    (s_rst_n),
      .in_data_i  (f2_data[go]),
      .in_vld_i   (f2_vld[go]),
      .in_rdy_o   (f2_rdy[go]),
      .out_data_o (out_data_o[go]),
      .out_vld_o  (out_vld_o[go]),
      .out_rdy_i  (out_rdy_i[go])
    );
  end

endmodule

// File: stream_disp_router.sv
// Router steering each format core's beats to a rotating output and merging them per port
module stream_disp_router (
  input  logic                                          clk,
  input  logic                                          s_rst_n,

  input  disp_pkg::out_beat_t [disp_pkg::FMT_CORE_NB-1:0] f1_data_i,
  input  logic [disp_pkg::FMT_CORE_NB-1:0]               f1_vld_i,
  output logic [disp_pkg::FMT_CORE_NB-1:0]               f1_rdy_o,

  output disp_pkg::out_beat_t [disp_pkg::OUT_NB-1:0]      f2_data_o,
  output logic [disp_pkg::OUT_NB-1:0]                    f2_vld_o,
  input  logic [disp_pkg::OUT_NB-1:0]                    f2_rdy_i
);

  import disp_pkg::*;

  // Per core beat counter and one-hot destination
  logic [FMT_CORE_NB-1:0][D_ITER_W-1:0] cnt_q;
  logic [FMT_CORE_NB-1:0][OUT_NB-1:0]   dest_q;
  logic [FMT_CORE_NB-1:0][OUT_NB-1:0]   dest_rot;
  logic [FMT_CORE_NB-1:0]               xfer;
  logic [FMT_CORE_NB-1:0]               last;

  // Used by the overlap check only
  logic [OUT_NB-1:0] dest_seen;
  logic              dest_overlap;

  // ----------------------------------------------------------
  // Destination tracking
  // ----------------------------------------------------------
  always_comb begin
    logic [2*OUT_NB-1:0] dbl;
    for (int c = 0; c < FMT_CORE_NB; c++) begin
      f1_rdy_o[c] = |(f2_rdy_i & dest_q[c]);
      xfer[c]     = f1_vld_i[c] & f1_rdy_o[c];
      last[c]     = (cnt_q[c] == D_ITER_W'(D_ITER_NB - 1));
      // Rotate left by the core count, wrapping around
      dbl         = {dest_q[c], dest_q[c]} << FMT_CORE_NB;
      dest_rot[c] = dbl[2*OUT_NB-1:OUT_NB];
    end
  end

  always_ff @(posedge clk) begin
    if (!s_rst_n) begin
      for (int c = 0; c < FMT_CORE_NB; c++) begin
        cnt_q[c]  <= '0;
        dest_q[c] <= OUT_NB'(1) << c;
      end
    end else begin
      for (int c = 0; c < FMT_CORE_NB; c++) begin
        if (xfer[c]) begin
          if (last[c]) begin
            cnt_q[c]  <= '0;
            dest_q[c] <= dest_rot[c];
          end else begin
            cnt_q[c] <= cnt_q[c] + 1'b1;
          end
        end
      end
    end
  end

  // ----------------------------------------------------------
  // Merge
  // ----------------------------------------------------------
  // Destination sets are disjoint so a plain OR is enough
  always_comb begin
    f2_vld_o  = '0;
    f2_data_o = '0;
    for (int c = 0; c < FMT_CORE_NB; c++) begin
      for (int o = 0; o < OUT_NB; o++) begin
        if (dest_q[c][o]) begin
          f2_vld_o[o]  = f2_vld_o[o] | f1_vld_i[c];
          f2_data_o[o] = f2_data_o[o] | f1_data_i[c];
        end
      end
    end
  end

  always_comb begin
    dest_seen    = '0;
    dest_overlap = 1'b0;
    for (int c = 0; c < FMT_CORE_NB; c++) begin
      dest_overlap = dest_overlap | (|(dest_seen & dest_q[c]));
      dest_seen    = dest_seen | dest_q[c];
    end
  end

  for (genvar gc = 0; gc < FMT_CORE_NB; gc++) begin : gen_onehot_chk
    assert property (@(posedge clk) disable iff (!s_rst_n) $onehot(dest_q[gc]));
  end

  assert property (@(posedge clk) disable iff (!s_rst_n) !dest_overlap);

endmodule

// File: stream_disp_format.sv
// Format core that serializes one group of coefficients into narrow output beats
module stream_disp_format (
  input  logic                clk,
  input  logic                s_rst_n,

  input  disp_pkg::grp_t      in_data_i,
  input  logic                in_vld_i,
  output logic                in_rdy_o,

  output disp_pkg::out_beat_t out_data_o,
  output logic                out_vld_o,
  input  logic                out_rdy_i
);

  import disp_pkg::*;

  // Held group and its pair state
  grp_t                grp_q;
  logic                vld_q;
  logic [D_ITER_W-1:0] idx_q;

  logic last;
  logic in_xfer;
  logic out_xfer;

  assign last     = (idx_q == D_ITER_W'(D_ITER_NB - 1));
  assign out_xfer = vld_q & out_rdy_i;

  // Free, or draining the last pair this cycle
  assign in_rdy_o = ~vld_q | (out_rdy_i & last);
  assign in_xfer  = in_vld_i & in_rdy_o;

  // ----------------------------------------------------------
  // Control
  // ----------------------------------------------------------
  always_ff @(posedge clk) begin
    if (!s_rst_n) begin
      vld_q <= 1'b0;
      idx_q <= '0;
    end else if (in_xfer) begin
      vld_q <= 1'b1;
      idx_q <= '0;
    end else if (out_xfer) begin
      if (last) begin
        vld_q <= 1'b0;
        idx_q <= '0;
      end else begin
        idx_q <= idx_q + 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (in_xfer) grp_q <= in_data_i;
  end

  // ----------------------------------------------------------
  // Output pair
  // ----------------------------------------------------------
  // Low pair first with the lower index in element 0
  always_comb begin
    for (int j = 0; j < OUT_COEF; j++) begin
      out_data_o[j] = grp_q[int'(idx_q)*OUT_COEF + j];
    end
  end

  assign out_vld_o = vld_q;

  // Pair index rests at zero while idle
  assert property (@(posedge clk) disable iff (!s_rst_n)
    !vld_q |-> (idx_q == '0));

endmodule

// File: stream_disp_fork.sv
// Fork that hands each half of an input beat to its format core exactly once
module stream_disp_fork (
  input  logic                                     clk,
  input  logic                                     s_rst_n,

  input  disp_pkg::in_beat_t                       s0_data_i,
  input  logic                                     s0_vld_i,
  output logic                                     s0_rdy_o,

  output disp_pkg::grp_t [disp_pkg::FMT_CORE_NB-1:0] f0_data_o,
  output logic [disp_pkg::FMT_CORE_NB-1:0]          f0_vld_o,
  input  logic [disp_pkg::FMT_CORE_NB-1:0]          f0_rdy_i
);

  import disp_pkg::*;

  // Cores that already took the current beat
  logic [FMT_CORE_NB-1:0] mask_q;
  logic [FMT_CORE_NB-1:0] mask_d;
  logic [FMT_CORE_NB-1:0] take;
  logic                   all_taken;

  // ----------------------------------------------------------
  // Split
  // ----------------------------------------------------------
  // Core c gets coefficients DISP_COEF*c up to DISP_COEF*c+DISP_COEF-1
  always_comb begin
    for (int c = 0; c < FMT_CORE_NB; c++) begin
      for (int j = 0; j < DISP_COEF; j++) begin
        f0_data_o[c][j] = s0_data_i[c*DISP_COEF + j];
      end
    end
  end

  assign f0_vld_o = {FMT_CORE_NB{s0_vld_i}} & ~mask_q;
  assign s0_rdy_o = &(f0_rdy_i | mask_q);

  // ----------------------------------------------------------
  // Taken mask
  // ----------------------------------------------------------
  assign take      = f0_vld_o & f0_rdy_i;
  assign all_taken = &(take | mask_q);
  assign mask_d    = all_taken ? '0 : (mask_q | take);

  always_ff @(posedge clk) begin
    if (!s_rst_n) mask_q <= '0;
    else          mask_q <= mask_d;
  end

  // Input stays valid while part of its beat is taken
  assert property (@(posedge clk) disable iff (!s_rst_n) (|mask_q) |-> s0_vld_i);

endmodule

// File: fifo_element.sv
// Two-entry valid/ready buffer with registered output and skid entry, any payload type
module fifo_element #(
  parameter type payload_t = logic
) (
  input  logic     clk,
  input  logic     s_rst_n,

  input  payload_t in_data_i,
  input  logic     in_vld_i,
  output logic     in_rdy_o,

  output payload_t out_data_o,
  output logic     out_vld_o,
  input  logic     out_rdy_i
);

  // Output stage and skid entry
  payload_t out_data_q;
  logic     out_vld_q;
  payload_t skid_data_q;
  logic     skid_vld_q;

  logic push;
  logic pop;
  logic stall;

  // Ready only while the skid entry is free
  assign in_rdy_o = ~skid_vld_q;
  assign push     = in_vld_i & ~skid_vld_q;
  assign pop      = out_vld_q & out_rdy_i;
  assign stall    = out_vld_q & ~out_rdy_i;

  always_ff @(posedge clk) begin
    if (!s_rst_n) begin
      out_vld_q  <= 1'b0;
      skid_vld_q <= 1'b0;
    end else if (skid_vld_q) begin
      // Skid drains into the output stage, which stays full
      if (pop) skid_vld_q <= 1'b0;
    end else if (push) begin
      if (stall) skid_vld_q <= 1'b1;
      else       out_vld_q  <= 1'b1;
    end else if (pop) begin
      out_vld_q <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (skid_vld_q) begin
      if (pop) out_data_q <= skid_data_q;
    end else if (push) begin
      if (stall) skid_data_q <= in_data_i;
      else       out_data_q  <= in_data_i;
    end
  end

  assign out_data_o = out_data_q;
  assign out_vld_o  = out_vld_q;

  // Held item must not change before it is taken
  assert property (@(posedge clk) disable iff (!s_rst_n)
    (out_vld_o && !out_rdy_i) |=> $stable(out_data_o));

endmodule

// File: disp_pkg.sv
// Shared sizes and payload types of the coefficient dispatcher, imported by every RTL file
package disp_pkg;

  // ----------------------------------------------------------
  // Sizes
  // ----------------------------------------------------------
  // Width of one coefficient
  localparam int OP_W = 16;

  // Coefficients per input beat
  localparam int IN_COEF = 8;

  // Consecutive coefficients sent to one destination
  localparam int DISP_COEF = 4;

  // Coefficients per output beat
  localparam int OUT_COEF = 2;

  // Output ports
  localparam int OUT_NB = 4;

  // One format core per group of DISP_COEF coefficients
  localparam int FMT_CORE_NB = IN_COEF / DISP_COEF;

  // Narrow beats needed to drain one group
  localparam int D_ITER_NB = DISP_COEF / OUT_COEF;
  localparam int D_ITER_W  = (D_ITER_NB > 1) ? $clog2(D_ITER_NB) : 1;

  // ----------------------------------------------------------
  // Payload types
  // ----------------------------------------------------------
  typedef logic [OP_W-1:0] coef_t;

  // Full input beat, coefficient 0 in element 0
  typedef coef_t [IN_COEF-1:0] in_beat_t;

  // Group handled by one format core
  typedef coef_t [DISP_COEF-1:0] grp_t;

  // Narrow beat toward one output port
  typedef coef_t [OUT_COEF-1:0] out_beat_t;

endpackage
